/* src.f */
+incdir+common
common/lsu_op_pkg.sv
common/mem_seq_pkg.sv
common/lsq_ifs.sv
lsq/lsq_alloc.sv
lsq/lsq_entry.sv
lsq/mem_sequencer.sv
src/fetch_queue.sv
src/lsu_top.sv
bench/tb_lsu.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_lsu
FILELIST  ?= src.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module lsu_top -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module tb_lsu import lsu_op_pkg::*; import mem_seq_pkg::*; ();

    localparam int WAIT_LIMIT = 3000;

    logic               clk = 1'b0;
    logic               rst;
    mem_op_e            mem_op;
    logic [31:0]        mem_addr, mem_data, fetch_pc, ram_addr, result_value, inst_value;
    logic [`TAG_W-1:0]  mem_tag, commit_tag, result_tag, load_head_tag;
    logic               fetch_req, ram_we, result_valid, inst_valid, lsq_full, ifq_full;
    logic [7:0]         ram_rdata, ram_wdata, rd_pending;

    logic [7:0]         ram    [512];      // RAM seen by the DUT
    logic [7:0]         shadow [512];      // Reference copy
    lsq_data_t          op_q [$];          // Ops awaiting their result in allocation order
    logic [31:0]        pc_q [$];
    logic [`TAG_W-1:0]  commit_q [$];
    int                 commit_cyc_q [$];
    int                 seed = 32'h559df644;
    int                 cyc = 0;
    int                 mismatches = 0;
    int                 failures = 0;
    int                 commit_delay = 0;
    logic               commit_en = 1'b1;
    logic               hold = 1'b0;       // Nothing may reach RAM while set
    logic [`TAG_W-1:0]  next_tag = 1;
    logic [`TAG_W-1:0]  first_tag;
    mem_op_e            op_list [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};

    lsu_top i_dut (.*);

    always #5 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic int bytes_of(mem_op_e op);
        acc_size_e s;
        case (op)
            OP_LB, OP_LBU, OP_SB: s = ACC_BYTE;
            OP_LH, OP_LHU, OP_SH: s = ACC_HALF;
            default:              s = ACC_WORD;
        endcase
        return (s == ACC_BYTE) ? 1 : (s == ACC_HALF) ? 2 : 4;
    endfunction

    function automatic logic [31:0] word_at(logic [31:0] a);
        logic [8:0] b;
        b = a[8:0];
        return {shadow[b + 9'd3], shadow[b + 9'd2], shadow[b + 9'd1], shadow[b]};
    endfunction

    function automatic logic [31:0] load_value(mem_op_e op, logic [31:0] a);
        logic [31:0] w;
        w = word_at(a);
        case (op)
            OP_LB:   return {{24{w[7]}}, w[7:0]};
            OP_LBU:  return {24'd0, w[7:0]};
            OP_LH:   return {{16{w[15]}}, w[15:0]};
            OP_LHU:  return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic end_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp) else begin
            mismatches++;
            $display("mismatch at %0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_result();
        lsq_data_t   e;
        logic [31:0] exp_val;
        if (op_q.size() == 0) begin
            failures++;
            $display("result_valid pulsed at %0t with no op pending", $time);
        end else begin
            e = op_q.pop_front();
            exp_val = 32'd0;
            if (e.op inside {OP_SB, OP_SH, OP_SW}) begin
                for (int k = 0; k < bytes_of(e.op); k++) begin
                    shadow[e.addr[8:0] + k] = e.data[8*k +: 8];
                end
            end else begin
                exp_val = load_value(e.op, e.addr);
            end
            assert (result_tag == e.tag) else begin
                mismatches++;
                $display("mismatch at %0t result_tag got %0d exp %0d", $time, result_tag, e.tag);
            end
            assert (result_value == exp_val) else begin
                mismatches++;
                $display("mismatch at %0t result_value got %h exp %h", $time, result_value,
                         exp_val);
            end
        end
    endtask

    task automatic check_inst();
        logic [31:0] exp_word;
        if (pc_q.size() == 0) begin
            failures++;
            $display("inst_valid pulsed at %0t with no fetch pending", $time);
        end else begin
            exp_word = word_at(pc_q.pop_front());
            assert (inst_value == exp_word) else begin
                mismatches++;
                $display("mismatch at %0t inst_value got %h exp %h", $time, inst_value, exp_word);
            end
        end
    endtask

    // RAM model and result monitor sampled mid cycle
    always @(negedge clk) begin
        if (rst) begin
            if (ram_we) begin
                ram[ram_addr[8:0]] = ram_wdata;
            end
            assert (!(hold && (ram_we || result_valid))) else begin
                failures++;
                $display("store or result appeared at %0t before the first commit", $time);
            end
            if (result_valid) check_result();
            if (inst_valid) check_inst();
        end
        rd_pending = ram[ram_addr[8:0]];
    end

    always @(posedge clk) begin
        #1 ram_rdata = rd_pending;        // One cycle read latency
    end

    // Commits in allocation order with a random gap
    always @(posedge clk) begin
        #1 commit_tag = '0;
        if (commit_delay > 0) begin
            commit_delay--;
        end else if (rst && commit_en && commit_q.size() != 0 && commit_cyc_q[0] < cyc) begin
            commit_tag = commit_q.pop_front();
            void'(commit_cyc_q.pop_front());
            hold = 1'b0;
            commit_delay = {$random(seed)} % 4;
        end
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================
    task automatic tick();
        @(posedge clk);
        #1;
        mem_op    = OP_NONE;
        fetch_req = 1'b0;
    endtask

    task automatic put_op(mem_op_e op, logic [31:0] a, logic [31:0] d);
        lsq_data_t e;
        e.op     = op;
        e.addr   = a;
        e.data   = d;
        e.tag    = next_tag;
        mem_op   = op;
        mem_addr = a;
        mem_data = d;
        mem_tag  = next_tag;
        op_q.push_back(e);
        commit_q.push_back(next_tag);
        commit_cyc_q.push_back(cyc);
        next_tag = (next_tag == 7) ? 1 : next_tag + 1;
    endtask

    task automatic put_random_op();
        mem_op_e op;
        int      n;
        op = op_list[{$random(seed)} % 8];
        n  = bytes_of(op);
        put_op(op, 32'h100 + ({$random(seed)} % (256 / n)) * n, $random(seed));
    endtask

    task automatic put_fetch(logic [31:0] pc);
        fetch_req = 1'b1;
        fetch_pc  = pc;
        pc_q.push_back(pc);
    endtask

    task automatic send_op(mem_op_e op, logic [31:0] a, logic [31:0] d);
        int n;
        n = 0;
        tick();
        while (lsq_full && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (n == WAIT_LIMIT) begin
            failures++;
            $display("timeout waiting for lsq_full to drop");
        end else begin
            put_op(op, a, d);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        tick();
        while ((op_q.size() != 0 || pc_q.size() != 0) && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (n == WAIT_LIMIT) begin
            failures++;
            $display("timeout waiting for queued ops and fetches to finish");
        end
    endtask

    task automatic check_head_tag(logic [`TAG_W-1:0] exp_tag);
        assert (load_head_tag == exp_tag) else begin
            mismatches++;
            $display("mismatch at %0t load_head_tag got %0d exp %0d", $time, load_head_tag,
                     exp_tag);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        rst        = 1'b0;
        mem_op     = OP_NONE;
        mem_addr   = '0;
        mem_data   = '0;
        mem_tag    = '0;
        commit_tag = '0;
        fetch_req  = 1'b0;
        fetch_pc   = '0;
        ram_rdata  = '0;
        rd_pending = '0;
        for (int a = 0; a < 512; a++) begin
            ram[a]    = $random(seed);
            shadow[a] = ram[a];
        end
        repeat (16) @(posedge clk);
        #1 rst = 1'b1;
        @(negedge clk);
        compare_value("result_valid", result_valid, 0);
        compare_value("inst_valid", inst_valid, 0);
        compare_value("ram_we", ram_we, 0);
        compare_value("lsq_full", lsq_full, 0);
        compare_value("ifq_full", ifq_full, 0);
        compare_value("load_head_tag", load_head_tag, 0);

        // Store then load back every size
        send_op(OP_SW, 32'h100, 32'h80F182A3);
        send_op(OP_SH, 32'h104, 32'h12349876);
        send_op(OP_SB, 32'h10A, 32'h000000FF);
        foreach (op_list[i]) begin
            if (!(op_list[i] inside {OP_SB, OP_SH, OP_SW})) begin
                send_op(op_list[i], 32'h100, 32'd0);
                send_op(op_list[i], 32'h104, 32'd0);
                if (bytes_of(op_list[i]) == 1) send_op(op_list[i], 32'h10A, 32'd0);
            end
        end
        wait_drain();

        // Queue fills with a load at the head while commits are held
        commit_en = 1'b0;
        hold      = 1'b1;
        first_tag = next_tag;
        for (int i = 0; i < 6; i++) begin
            tick();
            compare_value("lsq_full", lsq_full, 0);
            if (i == 0) put_op(OP_LW, 32'h100, 32'd0);
            else put_random_op();
        end
        tick();
        compare_value("lsq_full", lsq_full, 1);
        repeat (10) begin
            check_head_tag(first_tag);
            tick();
        end
        commit_en = 1'b1;
        wait_drain();
        check_head_tag('0);

        // Store at the head hides its tag
        commit_en = 1'b0;
        send_op(OP_SW, 32'h1F0, 32'hCAFE0001);
        tick();
        tick();
        check_head_tag('0);
        commit_en = 1'b1;
        wait_drain();

        // Long random mix of ops and fetches
        repeat (600) begin
            tick();
            if (!lsq_full && {$random(seed)} % 10 < 6) put_random_op();
            if (!ifq_full && {$random(seed)} % 10 < 3) put_fetch(({$random(seed)} % 64) * 4);
        end
        wait_drain();

        for (int a = 256; a < 512; a++) begin
            assert (ram[a] == shadow[a]) else begin
                mismatches++;
                $display("mismatch at %0t ram[%h] got %h exp %h", $time, a, ram[a], shadow[a]);
            end
        end
        end_run();
    end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top import lsu_op_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  mem_op_e             mem_op,
    input  logic [31:0]         mem_addr,
    input  logic [31:0]         mem_data,
    input  logic [`TAG_W-1:0]   mem_tag,
    input  logic [`TAG_W-1:0]   commit_tag,
    input  logic                fetch_req,
    input  logic [31:0]         fetch_pc,
    input  logic [7:0]          ram_rdata,
    output logic [31:0]         ram_addr,
    output logic                ram_we,
    output logic [7:0]          ram_wdata,
    output logic                result_valid,
    output logic [`TAG_W-1:0]   result_tag,
    output logic [31:0]         result_value,
    output logic                inst_valid,
    output logic [31:0]         inst_value,
    output logic [`TAG_W-1:0]   load_head_tag,
    output logic                lsq_full,
    output logic                ifq_full
);

    lsq_wr_if    wr_bus ();
    lsq_entry_if ent_bus [`LSQ_DEPTH] ();

    logic        pop_any;
    logic [31:0] fq_pc;
    logic        fq_valid;
    logic        fq_pop;

    lsq_alloc i_alloc (
        .clk      (clk),
        .rst      (rst),
        .op       (mem_op),
        .addr     (mem_addr),
        .data     (mem_data),
        .tag      (mem_tag),
        .pop_any  (pop_any),
        .wr       (wr_bus),
        .lsq_full (lsq_full)
    );

    // Memory op queue slots
    for (genvar i = 0; i < `LSQ_DEPTH; i++) begin : g_entry
        lsq_entry #(.INDEX(i)) i_entry (
            .clk        (clk),
            .rst        (rst),
            .wr         (wr_bus),
            .commit_tag (commit_tag),
            .ent        (ent_bus[i])
        );
    end

    mem_sequencer i_seq (
        .clk           (clk),
        .rst           (rst),
        .ent           (ent_bus),
        .fq_pc         (fq_pc),
        .fq_valid      (fq_valid),
        .fq_pop        (fq_pop),
        .pop_any       (pop_any),
        .ram_addr      (ram_addr),
        .ram_we        (ram_we),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata),
        .result_valid  (result_valid),
        .result_tag    (result_tag),
        .result_value  (result_value),
        .inst_valid    (inst_valid),
        .inst_value    (inst_value),
        .load_head_tag (load_head_tag)
    );

    fetch_queue i_fq (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_pc  (fetch_pc),
        .fq_pop    (fq_pop),
        .fq_pc     (fq_pc),
        .fq_valid  (fq_valid),
        .ifq_full  (ifq_full)
    );

endmodule

`default_nettype wire

/* src/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module fetch_queue (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_req,
    input  logic [31:0] fetch_pc,
    input  logic        fq_pop,
    output logic [31:0] fq_pc,
    output logic        fq_valid,
    output logic        ifq_full
);

    localparam int DEPTH = `IFQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [31:0]      pc_mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             push;
    logic             pop;

    assign push = fetch_req && (count != CNT_W'(DEPTH));
    assign pop  = fq_pop && (count != '0);

    always_comb begin
        count_nxt = count;
        if (push && !pop) begin
            count_nxt = count + 1'b1;
        end else if (!push && pop) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            ifq_full <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count    <= count_nxt;
            ifq_full <= (CNT_W'(DEPTH) - count_nxt) <= CNT_W'(`FULL_MARGIN);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr] <= fetch_pc;
        end
    end

    assign fq_pc    = pc_mem[rd_ptr];
    assign fq_valid = (count != '0);

endmodule

`default_nettype wire

/* lsq/mem_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module mem_sequencer import lsu_op_pkg::*; import mem_seq_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    lsq_entry_if.seq            ent [`LSQ_DEPTH],
    input  logic [31:0]         fq_pc,
    input  logic                fq_valid,
    output logic                fq_pop,
    output logic                pop_any,
    output logic [31:0]         ram_addr,
    output logic                ram_we,
    output logic [7:0]          ram_wdata,
    input  logic [7:0]          ram_rdata,
    output logic                result_valid,
    output logic [`TAG_W-1:0]   result_tag,
    output logic [31:0]         result_value,
    output logic                inst_valid,
    output logic [31:0]         inst_value,
    output logic [`TAG_W-1:0]   load_head_tag
);

    localparam int DEPTH = `LSQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [DEPTH-1:0]   ent_valid;
    logic [DEPTH-1:0]   ent_committed;
    lsq_data_t          ent_data [DEPTH];
    logic [PTR_W-1:0]   head;
    lsq_data_t          head_data;
    logic               head_ready;
    logic               head_is_load;
    logic               head_is_store;
    acc_size_e          head_size;
    logic [2:0]         head_bytes;

    seq_state_e         state;
    logic [2:0]         byte_cnt;
    logic [2:0]         last_cnt;      // byte_cnt value of the final cycle
    logic [2:0]         cap_idx;
    logic               is_fetch;
    logic               done_mem;
    mem_op_e            cur_op;
    logic [`TAG_W-1:0]  cur_tag;
    logic [31:0]        cur_addr;
    logic [31:0]        cur_data;
    logic [31:0]        load_buf;
    logic [31:0]        wr_shift;

    // ==================================================================
    // Head entry select
    // ==================================================================
    for (genvar i = 0; i < DEPTH; i++) begin : g_ent
        assign ent_valid[i]     = ent[i].valid;
        assign ent_committed[i] = ent[i].committed;
        assign ent_data[i]      = ent[i].contents;
        assign ent[i].pop       = done_mem && (head == PTR_W'(i));
    end

    assign head_data     = ent_data[head];
    assign head_ready    = ent_valid[head] && ent_committed[head];
    assign head_is_store = head_data.op inside {OP_SB, OP_SH, OP_SW};
    assign head_is_load  = head_data.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};

    // Lets the ROB commit the load at the head
    assign load_head_tag = (ent_valid[head] && head_is_load) ? head_data.tag : '0;

    always_comb begin
        case (head_data.op)
            OP_LB, OP_LBU, OP_SB: head_size = ACC_BYTE;
            OP_LH, OP_LHU, OP_SH: head_size = ACC_HALF;
            default:              head_size = ACC_WORD;
        endcase
    end

    always_comb begin
        case (head_size)
            ACC_BYTE: head_bytes = 3'd1;
            ACC_HALF: head_bytes = 3'd2;
            default:  head_bytes = 3'd4;
        endcase
    end

    // ==================================================================
    // Byte-serial state machine
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= SEQ_IDLE;
            head     <= '0;
            byte_cnt <= '0;
            is_fetch <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    byte_cnt <= '0;
                    if (head_ready) begin      // Committed op beats a fetch
                        is_fetch <= 1'b0;
                        state    <= head_is_store ? SEQ_STORE : SEQ_LOAD;
                    end else if (fq_valid) begin
                        is_fetch <= 1'b1;
                        state    <= SEQ_LOAD;
                    end
                end
                SEQ_STORE, SEQ_LOAD: begin
                    byte_cnt <= byte_cnt + 3'd1;
                    if (byte_cnt == last_cnt) begin
                        state <= SEQ_DONE;
                    end
                end
                SEQ_DONE: begin
                    if (!is_fetch) begin
                        head <= head + 1'b1;
                    end
                    state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign cap_idx = byte_cnt - 3'd1;

    // Access fields and load capture
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE) begin
            load_buf <= '0;
            if (head_ready) begin
                cur_op   <= head_data.op;
                cur_tag  <= head_data.tag;
                cur_addr <= head_data.addr;
                cur_data <= head_data.data;
                last_cnt <= head_is_store ? head_bytes - 3'd1 : head_bytes;
            end else begin
                cur_op   <= OP_LW;
                cur_tag  <= '0;
                cur_addr <= fq_pc;
                last_cnt <= 3'd4;          // Word read plus one capture cycle
            end
        end else if (state == SEQ_LOAD && byte_cnt != 3'd0) begin
            load_buf[{cap_idx[1:0], 3'b000} +: 8] <= ram_rdata;
        end
    end

    // RAM port
    assign wr_shift  = cur_data >> {byte_cnt, 3'b000};
    assign ram_we    = (state == SEQ_STORE);
    assign ram_wdata = wr_shift[7:0];
    assign ram_addr  = cur_addr + {29'd0, byte_cnt};

    // ==================================================================
    // Results
    // ==================================================================
    assign done_mem     = (state == SEQ_DONE) && !is_fetch;
    assign pop_any      = done_mem;
    assign result_valid = done_mem;
    assign result_tag   = cur_tag;
    assign inst_valid   = (state == SEQ_DONE) && is_fetch;
    assign fq_pop       = inst_valid;
    assign inst_value   = load_buf;

    always_comb begin
        case (cur_op)
            OP_LB:   result_value = {{24{load_buf[7]}}, load_buf[7:0]};
            OP_LBU:  result_value = {24'd0, load_buf[7:0]};
            OP_LH:   result_value = {{16{load_buf[15]}}, load_buf[15:0]};
            OP_LHU:  result_value = {16'd0, load_buf[15:0]};
            OP_LW:   result_value = load_buf;
            default: result_value = 32'd0;     // Stores
        endcase
    end

endmodule

`default_nettype wire

/* lsq/lsq_entry.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsq_entry import lsu_op_pkg::*; #(
    parameter int INDEX = 0
) (
    input  logic                clk,
    input  logic                rst,
    lsq_wr_if.entry             wr,
    input  logic [`TAG_W-1:0]   commit_tag,
    lsq_entry_if.entry          ent
);

    logic      valid_q;
    logic      committed_q;
    lsq_data_t slot;

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q     <= 1'b0;
            committed_q <= 1'b0;
        end else if (wr.we[INDEX]) begin
            valid_q     <= 1'b1;
            committed_q <= 1'b0;       // Waits for its own commit
        end else if (ent.pop) begin
            valid_q     <= 1'b0;
            committed_q <= 1'b0;
        end else if (valid_q && commit_tag != '0 && commit_tag == slot.tag) begin
            committed_q <= 1'b1;
        end
    end

    // Op fields
    always_ff @(posedge clk) begin
        if (wr.we[INDEX]) begin
            slot.op   <= wr.op;
            slot.addr <= wr.addr;
            slot.data <= wr.data;
            slot.tag  <= wr.tag;
        end
    end

    assign ent.valid     = valid_q;
    assign ent.committed = committed_q;
    assign ent.contents  = slot;

endmodule

`default_nettype wire

/* lsq/lsq_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsq_alloc import lsu_op_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  mem_op_e             op,
    input  logic [31:0]         addr,
    input  logic [31:0]         data,
    input  logic [`TAG_W-1:0]   tag,
    input  logic                pop_any,
    lsq_wr_if.alloc             wr,
    output logic                lsq_full
);

    localparam int DEPTH = `LSQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic [DEPTH-1:0] we_onehot;
    logic             push;

    assign push = (op != OP_NONE);

    always_comb begin
        we_onehot       = '0;
        we_onehot[tail] = push;
    end

    // Occupancy after this cycle
    always_comb begin
        count_nxt = count;
        if (push && !pop_any) begin
            count_nxt = count + 1'b1;
        end else if (!push && pop_any) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            tail     <= '0;
            count    <= '0;
            lsq_full <= 1'b0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            count    <= count_nxt;
            lsq_full <= (CNT_W'(DEPTH) - count_nxt) <= CNT_W'(`FULL_MARGIN);
        end
    end

    assign wr.we   = we_onehot;
    assign wr.op   = op;
    assign wr.addr = addr;
    assign wr.data = data;
    assign wr.tag  = tag;

endmodule

`default_nettype wire

/* common/lsq_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

// ======================================================================
// Allocator to queue entries
// ======================================================================
interface lsq_wr_if import lsu_op_pkg::*; ();

    logic [`LSQ_DEPTH-1:0] we;     // One-hot write strobe
    mem_op_e               op;
    logic [31:0]           addr;
    logic [31:0]           data;
    logic [`TAG_W-1:0]     tag;

    modport alloc (
        output we, op, addr, data, tag
    );

    modport entry (
        input we, op, addr, data, tag
    );

endinterface

// ======================================================================
// One queue entry to the sequencer
// ======================================================================
interface lsq_entry_if import lsu_op_pkg::*; ();

    logic      valid;
    logic      committed;
    lsq_data_t contents;
    logic      pop;                // Head entry retires

    modport entry (
        output valid, committed, contents,
        input  pop
    );

    modport seq (
        input  valid, committed, contents,
        output pop
    );

endinterface

`default_nettype wire

/* common/mem_seq_pkg.sv */
`default_nettype none

package mem_seq_pkg;

    // Byte-serial RAM sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_STORE,
        SEQ_LOAD,
        SEQ_DONE
    } seq_state_e;

    // Access width
    typedef enum logic [1:0] {
        ACC_BYTE,
        ACC_HALF,
        ACC_WORD
    } acc_size_e;

endpackage

`default_nettype wire

/* common/lsu_op_pkg.sv */
`default_nettype none

`include "lsu_config.svh"

package lsu_op_pkg;

    // Memory opcodes with the core decoder's codes
    typedef enum logic [4:0] {
        OP_LB   = 5'b10010,
        OP_LH   = 5'b10011,
        OP_LW   = 5'b10100,
        OP_LBU  = 5'b10101,
        OP_LHU  = 5'b10110,
        OP_SB   = 5'b10111,
        OP_SH   = 5'b11000,
        OP_SW   = 5'b11001,
        OP_NONE = 5'b11111     // No op this cycle
    } mem_op_e;

    // Contents of one queue slot
    typedef struct packed {
        mem_op_e            op;
        logic [31:0]        addr;
        logic [31:0]        data;   // Store data
        logic [`TAG_W-1:0]  tag;
    } lsq_data_t;

endpackage

`default_nettype wire

/* common/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Queue depths
`define LSQ_DEPTH    8
`define IFQ_DEPTH    8

// ROB tag width
// Tag 0 is reserved and never names an op
`define TAG_W        3

// Full is reported once free slots drop to this many
`define FULL_MARGIN  2

`endif
